// File: execute.sv
`timescale 1ns/1ps

module execute import rv32_pkg::*; (
   input  logic           clock,
   input  logic           rst_n,
   input  logic           hold,
   issue_link_if.consumer issue,
   output logic           retire_valid,
   output addr_t          retire_pc,
   output reg_index_t     retire_rd,
   output word_t          retire_value
);

   logic [6:0]   opcode;
   logic [2:0]   funct3;
   logic [6:0]   funct7;
   reg_index_t   rd;
   reg_index_t   rs1;
   reg_index_t   rs2;
   word_t        imm_i;
   word_t        imm_u;
   word_t        operand_a;
   word_t        operand_b;
   word_t        read_b;
   word_t        alu_result;
   word_t        result;
   logic         funct3_supported;
   logic         do_pop;
   logic         writes;
   instr_class_t instr_class;

   assign opcode = issue.instruction[6:0];
   assign rd     = issue.instruction[11:7];
   assign funct3 = issue.instruction[14:12];
   assign rs1    = issue.instruction[19:15];
   assign rs2    = issue.instruction[24:20];
   assign funct7 = issue.instruction[31:25];

   assign imm_i = {{20{issue.instruction[31]}}, issue.instruction[31:20]};
   assign imm_u = {issue.instruction[31:12], 12'b0};

   register_file register_file_i (
      .clock        (clock),
      .rst_n        (rst_n),
      .read_a_index (rs1),
      .read_b_index (rs2),
      .read_a       (operand_a),
      .read_b       (read_b),
      .write_enable (writes),
      .write_index  (rd),
      .write_value  (result)
   );

   // No shifts, no sltu.
   always_comb begin
      case (funct3)
         FUNCT3_ADD, FUNCT3_SLT, FUNCT3_XOR, FUNCT3_OR, FUNCT3_AND: funct3_supported = 1'b1;
         default: funct3_supported = 1'b0;
      endcase
   end

   always_comb begin
      case (opcode)
         OPCODE_OP_IMM: instr_class = funct3_supported ? class_alu_imm : class_none;
         OPCODE_OP:     instr_class = funct3_supported ? class_alu_reg : class_none;
         OPCODE_LUI:    instr_class = class_lui;
         default:       instr_class = class_none;
      endcase
   end

   assign operand_b = (instr_class == class_alu_imm) ? imm_i : read_b;

   always_comb begin
      case (funct3)
         FUNCT3_ADD: begin
            if (instr_class == class_alu_reg && funct7 == FUNCT7_SUB) begin
               alu_result = operand_a - operand_b;
            end else begin
               alu_result = operand_a + operand_b;
            end
         end
         FUNCT3_SLT: alu_result = word_t'($signed(operand_a) < $signed(operand_b));   // Signed.
         FUNCT3_XOR: alu_result = operand_a ^ operand_b;
         FUNCT3_OR:  alu_result = operand_a | operand_b;
         FUNCT3_AND: alu_result = operand_a & operand_b;
         default:    alu_result = '0;
      endcase
   end

   assign result = (instr_class == class_lui) ? imm_u : alu_result;

   assign do_pop    = issue.valid && !hold;
   assign issue.pop = do_pop;
   // Write lands at the pop edge, so the next head reads it directly.
   assign writes = do_pop && (instr_class != class_none) && (rd != '0);

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= do_pop;
      end
   end

   always_ff @(posedge clock) begin
      if (do_pop) begin
         retire_pc    <= issue.pc;
         retire_rd    <= writes ? rd : '0;       // No-op reports x0.
         retire_value <= writes ? result : '0;
      end
   end

   // Waiting head must stay put until it is popped.
   head_held_a: assert property (@(posedge clock) disable iff (!rst_n)
      (issue.valid && !issue.pop) |=>
         (issue.valid && $stable(issue.pc) && $stable(issue.instruction)));

endmodule

// File: fetch.sv
`timescale 1ns/1ps

module fetch import rv32_pkg::*; (
   input  logic                  clock,
   input  logic                  rst_n,
   input  logic                  run,
   input  logic [4:0]            program_length,
   output logic                  read_enable,
   output imem_index_t           read_index,
   input  word_t                 read_word,
   fetch_link_if.producer        link
);

   fetch_state_t state;
   fetch_state_t state_next;
   addr_t        pc;
   addr_t        pc_q;
   credit_t      credits;
   logic         valid_q;
   logic [4:0]   pc_index;

   assign pc_index = pc[6:2];
   assign read_index = pc[5:2];

   // Credit is spent here, when the read goes out.
   assign read_enable = (state == fetch_run) && run && (credits != '0)
                        && (pc_index < program_length);

   always_comb begin
      state_next = state;
      case (state)
         fetch_idle: begin
            if (run) state_next = fetch_run;
         end
         fetch_run: begin
            if (!run) begin
               state_next = fetch_idle;
            end else if (pc_index >= program_length) begin
               state_next = fetch_drained;
            end
         end
         fetch_drained: begin
            if (!run) state_next = fetch_idle;   // Wait for run to drop.
         end
         default: state_next = fetch_idle;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         state   <= fetch_idle;
         pc      <= '0;
         credits <= credit_t'(QUEUE_DEPTH);
         valid_q <= 1'b0;
      end else begin
         state   <= state_next;
         credits <= credits + credit_t'(link.credit) - credit_t'(read_enable);
         valid_q <= read_enable;
         if (state == fetch_idle) begin
            pc <= '0;
         end else if (read_enable) begin
            pc <= pc + 32'd4;
         end
      end
   end

   // Pairs the pc with the word coming back from memory.
   always_ff @(posedge clock) begin
      if (read_enable) pc_q <= pc;
   end

   assign link.valid       = valid_q;
   assign link.pc          = pc_q;
   assign link.instruction = read_word;

   credit_bound_a: assert property (@(posedge clock) disable iff (!rst_n)
      credits <= credit_t'(QUEUE_DEPTH));

   // A word on the link still owns the credit it spent.
   valid_spent_a: assert property (@(posedge clock) disable iff (!rst_n)
      link.valid |-> (credits < credit_t'(QUEUE_DEPTH)));

endmodule

// File: instruction_links.sv
`timescale 1ns/1ps

interface fetch_link_if import rv32_pkg::*;;
   logic  valid;
   logic  credit;   // One credit back per cycle high.
   addr_t pc;
   word_t instruction;

   modport producer (
      output valid,
      output pc,
      output instruction,
      input  credit
   );

   modport consumer (
      input  valid,
      input  pc,
      input  instruction,
      output credit
   );
endinterface

interface issue_link_if import rv32_pkg::*;;
   logic  valid;
   logic  pop;
   addr_t pc;
   word_t instruction;

   modport producer (
      output valid,
      output pc,
      output instruction,
      input  pop
   );

   modport consumer (
      input  valid,
      input  pc,
      input  instruction,
      output pop
   );
endinterface

// File: instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory import rv32_pkg::*; (
   input  logic        clock,
   input  logic        load_enable,
   input  imem_index_t load_index,
   input  word_t       load_word,
   input  logic        read_enable,
   input  imem_index_t read_index,
   output word_t       read_word
);

   word_t words [IMEM_WORDS];
   word_t read_word_q;

   // Load port for the program image.
   always_ff @(posedge clock) begin
      if (load_enable) begin
         words[load_index] <= load_word;
      end
   end

   always_ff @(posedge clock) begin
      if (read_enable) begin
         read_word_q <= words[read_index];   // One cycle read latency.
      end
   end

   assign read_word = read_word_q;

endmodule

// File: instruction_queue.sv
`timescale 1ns/1ps

module instruction_queue import rv32_pkg::*; (
   input  logic           clock,
   input  logic           rst_n,
   fetch_link_if.consumer push_side,
   issue_link_if.producer pop_side
);

   addr_t      pc_store    [QUEUE_DEPTH];
   word_t      instr_store [QUEUE_DEPTH];
   queue_ptr_t write_ptr;
   queue_ptr_t read_ptr;
   credit_t    count;
   logic       do_push;
   logic       do_pop;

   assign do_push = push_side.valid;
   assign do_pop  = pop_side.valid && pop_side.pop;

   // Storage is payload only.
   always_ff @(posedge clock) begin
      if (do_push) begin
         pc_store[write_ptr]    <= push_side.pc;
         instr_store[write_ptr] <= push_side.instruction;
      end
   end

   // Pointers wrap on their own, depth is a power of two.
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         write_ptr <= '0;
         read_ptr  <= '0;
         count     <= '0;
      end else begin
         if (do_push) write_ptr <= write_ptr + 1'b1;
         if (do_pop) read_ptr <= read_ptr + 1'b1;
         count <= count + credit_t'(do_push) - credit_t'(do_pop);
      end
   end

   assign pop_side.valid       = (count != '0);
   assign pop_side.pc          = pc_store[read_ptr];
   assign pop_side.instruction = instr_store[read_ptr];

   assign push_side.credit = do_pop;   // Slot freed, credit goes back now.

   no_push_full_a: assert property (@(posedge clock) disable iff (!rst_n)
      push_side.valid |-> (count != credit_t'(QUEUE_DEPTH)));

   // Execute must only pop what the head shows.
   no_pop_empty_a: assert property (@(posedge clock) disable iff (!rst_n)
      pop_side.pop |-> pop_side.valid);

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file import rv32_pkg::*; (
   input  logic       clock,
   input  logic       rst_n,
   input  reg_index_t read_a_index,
   input  reg_index_t read_b_index,
   output word_t      read_a,
   output word_t      read_b,
   input  logic       write_enable,
   input  reg_index_t write_index,
   input  word_t      write_value
);

   word_t regs [1:31];   // No storage for x0.

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable && write_index != '0) begin
         regs[write_index] <= write_value;
      end
   end

   assign read_a = (read_a_index == '0) ? '0 : regs[read_a_index];
   assign read_b = (read_b_index == '0) ? '0 : regs[read_b_index];

endmodule

// File: rv32_core.sv
`timescale 1ns/1ps

module rv32_core import rv32_pkg::*; (
   input  logic        clock,
   input  logic        rst_n,
   input  logic        load_enable,
   input  imem_index_t load_index,
   input  word_t       load_word,
   input  logic        run,
   input  logic [4:0]  program_length,
   input  logic        hold,
   output logic        retire_valid,
   output addr_t       retire_pc,
   output reg_index_t  retire_rd,
   output word_t       retire_value
);

   logic        imem_read_enable;
   imem_index_t imem_read_index;
   word_t       imem_read_word;

   fetch_link_if fetch_link ();
   issue_link_if issue_link ();

   instruction_memory instruction_memory_i (
      .clock       (clock),
      .load_enable (load_enable),
      .load_index  (load_index),
      .load_word   (load_word),
      .read_enable (imem_read_enable),
      .read_index  (imem_read_index),
      .read_word   (imem_read_word)
   );

   fetch fetch_i (
      .clock          (clock),
      .rst_n          (rst_n),
      .run            (run),
      .program_length (program_length),
      .read_enable    (imem_read_enable),
      .read_index     (imem_read_index),
      .read_word      (imem_read_word),
      .link           (fetch_link.producer)
   );

   instruction_queue instruction_queue_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .push_side (fetch_link.consumer),
      .pop_side  (issue_link.producer)
   );

   execute execute_i (
      .clock        (clock),
      .rst_n        (rst_n),
      .hold         (hold),
      .issue        (issue_link.consumer),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc),
      .retire_rd    (retire_rd),
      .retire_value (retire_value)
   );

endmodule

// File: rv32_pkg.sv
package rv32_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [4:0]  reg_index_t;
   typedef logic [3:0]  imem_index_t;
   typedef logic [2:0]  credit_t;

   localparam int IMEM_WORDS = 16;
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

   typedef logic [QUEUE_PTR_WIDTH-1:0] queue_ptr_t;

   // Major opcodes, instruction bits 6:0.
   localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPCODE_OP     = 7'b0110011;
   localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

   localparam logic [2:0] FUNCT3_ADD = 3'b000;
   localparam logic [2:0] FUNCT3_SLT = 3'b010;
   localparam logic [2:0] FUNCT3_XOR = 3'b100;
   localparam logic [2:0] FUNCT3_OR  = 3'b110;
   localparam logic [2:0] FUNCT3_AND = 3'b111;

   localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

   typedef enum logic [1:0] {
      fetch_idle,
      fetch_run,
      fetch_drained
   } fetch_state_t;

   // Everything outside the supported set decodes to class_none.
   typedef enum logic [1:0] {
      class_alu_imm,
      class_alu_reg,
      class_lui,
      class_none
   } instr_class_t;

endpackage

// File: sim.f
rv32_pkg.sv
instruction_links.sv
instruction_memory.sv
fetch.sv
instruction_queue.sv
register_file.sv
execute.sv
rv32_core.sv
tb_rv32_core.sv

// File: tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core import rv32_pkg::*;;

   localparam int RESET_CYCLES = 8;
   localparam int CYCLES_PER_ROW = 40;
   localparam int ARITH_ROWS = 12;
   localparam int UNSUPPORTED_ROWS = 5;
   localparam int QUIET_CYCLES = 10;

   logic        clock;
   logic        rst_n;
   logic        load_enable;
   imem_index_t load_index;
   word_t       load_word;
   logic        run;
   logic [4:0]  program_length;
   logic        hold;
   logic        retire_valid;
   addr_t       retire_pc;
   reg_index_t  retire_rd;
   word_t       retire_value;

   string      row_name [$];
   word_t      row_instr [$];
   reg_index_t row_rd [$];
   word_t      row_value [$];

   int   retired_count = 0;
   int   error_count = 0;
   int   check_count = 0;
   logic hold_at_edge = 1'b0;   // Hold as execute saw it at the last edge.

   rv32_core rv32_core_i (
      .clock          (clock),
      .rst_n          (rst_n),
      .load_enable    (load_enable),
      .load_index     (load_index),
      .load_word      (load_word),
      .run            (run),
      .program_length (program_length),
      .hold           (hold),
      .retire_valid   (retire_valid),
      .retire_pc      (retire_pc),
      .retire_rd      (retire_rd),
      .retire_value   (retire_value)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   function automatic word_t itype(input logic [2:0] funct3, input reg_index_t rd,
                                   input reg_index_t rs1, input logic [11:0] imm);
      return {imm, rs1, funct3, rd, 7'b0010011};
   endfunction

   function automatic word_t rtype(input logic [6:0] funct7, input logic [2:0] funct3,
                                   input reg_index_t rd, input reg_index_t rs1,
                                   input reg_index_t rs2);
      return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
   endfunction

   function automatic word_t utype(input reg_index_t rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   task automatic add_row(input string name, input word_t instr, input reg_index_t rd,
                          input word_t value);
      row_name.push_back(name);
      row_instr.push_back(instr);
      row_rd.push_back(rd);
      row_value.push_back(value);
   endtask

   task automatic clear_rows();
      row_name.delete();
      row_instr.delete();
      row_rd.delete();
      row_value.delete();
   endtask

   // Registers start at zero after reset.
   task automatic build_arith_table();
      clear_rows();
      add_row("addi_pos", itype(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
      add_row("addi_neg", itype(3'b000, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd);
      add_row("add_dep", rtype(7'd0, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'd2);
      add_row("sub", rtype(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'd8);
      add_row("slt_neg", rtype(7'd0, 3'b010, 5'd5, 5'd2, 5'd1), 5'd5, 32'd1);
      add_row("slti_neg", itype(3'b010, 5'd6, 5'd1, 12'hfff), 5'd6, 32'd0);
      add_row("xori", itype(3'b100, 5'd7, 5'd1, 12'h0f0), 5'd7, 32'h0000_00f5);
      add_row("or_chain", rtype(7'd0, 3'b110, 5'd8, 5'd7, 5'd4), 5'd8, 32'h0000_00fd);
      add_row("and_chain", rtype(7'd0, 3'b111, 5'd9, 5'd8, 5'd2), 5'd9, 32'h0000_00fd);
      add_row("lui", utype(5'd10, 20'h12345), 5'd10, 32'h1234_5000);
      add_row("ori_x0", itype(3'b110, 5'd0, 5'd10, 12'h055), 5'd0, 32'd0);
      add_row("andi_x0_src", itype(3'b111, 5'd11, 5'd0, 12'hfff), 5'd11, 32'd0);
   endtask

   // Carries on from the register state left by the first program.
   task automatic build_unsupported_table();
      clear_rows();
      add_row("xor", rtype(7'd0, 3'b100, 5'd12, 5'd10, 5'd7), 5'd12, 32'h1234_50f5);
      add_row("jal_noop", {20'h00000, 5'd13, 7'b1101111}, 5'd0, 32'd0);
      add_row("add_after_noop", rtype(7'd0, 3'b000, 5'd13, 5'd13, 5'd12), 5'd13,
              32'h1234_50f5);
      add_row("slt_vs_x0", rtype(7'd0, 3'b010, 5'd14, 5'd2, 5'd0), 5'd14, 32'd1);
      add_row("addi_min", itype(3'b000, 5'd15, 5'd14, 12'h800), 5'd15, 32'hffff_f801);
   endtask

   task automatic load_program();
      for (int i = 0; i < row_instr.size(); i++) begin
         @(posedge clock);
         load_enable <= 1'b1;
         load_index  <= imem_index_t'(i);
         load_word   <= row_instr[i];
      end
      @(posedge clock);
      load_enable <= 1'b0;
   endtask

   task automatic run_program();
      int rows;
      rows = row_instr.size();
      retired_count = 0;
      @(posedge clock);
      run            <= 1'b1;
      program_length <= 5'(rows);
      while (retired_count < rows) begin
         @(posedge clock);
         hold <= (retired_count >= rows / 2) && ($urandom % 3 == 0);
      end
      hold <= 1'b0;
      repeat (QUIET_CYCLES) @(posedge clock);   // Nothing more may retire.
      assert (retired_count == rows) else begin
         $display("Wrong number of retirements: %0d instead of %0d", retired_count, rows);
         error_count++;
      end
      run <= 1'b0;
      repeat (2) @(posedge clock);
   endtask

   task automatic check_retirement();
      int idx;
      idx = retired_count;
      retired_count++;
      assert (!hold_at_edge) else begin
         $display("Instruction retired although hold was high at the previous edge");
         error_count++;
      end
      assert (idx < row_instr.size()) else begin
         $display("Unexpected retirement past the end of the program, pc %h", retire_pc);
         error_count++;
      end
      if (idx < row_instr.size()) begin
         check_count++;
         assert (retire_pc === addr_t'(idx * 4)) else begin
            $display("mismatch %s pc: expected %h, actual %h", row_name[idx],
                     addr_t'(idx * 4), retire_pc);
            error_count++;
         end
         assert (retire_rd === row_rd[idx]) else begin
            $display("mismatch %s rd: expected %0d, actual %0d", row_name[idx],
                     row_rd[idx], retire_rd);
            error_count++;
         end
         assert (retire_value === row_value[idx]) else begin
            $display("mismatch %s value: expected %h, actual %h", row_name[idx],
                     row_value[idx], retire_value);
            error_count++;
         end
      end
   endtask

   // Outputs are stable at the falling edge.
   always @(negedge clock) begin
      if (rst_n) begin
         if (retire_valid) check_retirement();
         hold_at_edge = hold;
      end else begin
         hold_at_edge = 1'b0;
      end
   end

   task automatic print_summary();
      $display("Retirements checked: %0d, errors: %0d", check_count, error_count);
   endtask

   initial begin
      void'($urandom(14));
      rst_n          = 1'b0;
      load_enable    = 1'b0;
      load_index     = '0;
      load_word      = '0;
      run            = 1'b0;
      program_length = '0;
      hold           = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      rst_n <= 1'b1;
      build_arith_table();
      load_program();
      run_program();
      build_unsupported_table();
      load_program();
      run_program();
      print_summary();
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      repeat (RESET_CYCLES + CYCLES_PER_ROW * (ARITH_ROWS + UNSUPPORTED_ROWS)) begin
         @(posedge clock);
      end
      $display("Timeout, the programs did not finish retiring in time");
      print_summary();
      $display("Simulation FAILED");
      $finish;
   end

endmodule
